// ==== sw_pkg.sv ====
package sw_pkg;

    ////////////////////////////////////////////////////////////
    // time representation
    ////////////////////////////////////////////////////////////

    // stopwatch time in centiseconds, 59:59.99 needs 19 bits
    typedef logic [18:0] time_cs_t;

    localparam time_cs_t max_time_cs       = 19'd359999; // 59:59.99
    localparam time_cs_t minute_cs         = 19'd6000;
    localparam time_cs_t second_cs         = 19'd100;
    localparam time_cs_t default_preset_cs = minute_cs;  // countdown used when preset is 0

    ////////////////////////////////////////////////////////////
    // tick prescaler
    ////////////////////////////////////////////////////////////

    // clocks per centisecond tick
    // a 100 MHz board build uses 1000000 here
    localparam logic [31:0] tick_div = 32'd4;

    // wide enough for the board divide of 1000000
    typedef logic [19:0] tick_cnt_t;

    ////////////////////////////////////////////////////////////
    // mode control
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        st_program,     // preset editing, display shows the preset
        st_ready,       // start value loaded, waiting for start
        st_running,
        st_paused,
        st_expired      // countdown hit zero
    } sw_state_t;

endpackage

// ==== sw_input_cond.sv ====
`timescale 1ns/1ps

module sw_input_cond (
    input  logic clk,
    input  logic rst_n,
    input  logic start_stop,
    input  logic clear,
    input  logic inc,
    input  logic prog,
    input  logic up,
    input  logic min_sel,
    output logic start_stop_stb,
    output logic clear_stb,
    output logic inc_stb,
    output logic prog_s,
    output logic up_s,
    output logic min_sel_s
);

    // bit order: min_sel, up, prog, inc, clear, start_stop
    logic [5:0] sync1;
    logic [5:0] sync2;
    logic [2:0] btn_prev;  // buttons only, for edge detect
    logic [2:0] btn_stb;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync1    <= '0;
            sync2    <= '0;
            btn_prev <= '0;
            btn_stb  <= '0;
        end else begin
            sync1    <= {min_sel, up, prog, inc, clear, start_stop};
            sync2    <= sync1;
            btn_prev <= sync2[2:0];
            btn_stb  <= sync2[2:0] & ~btn_prev; // rising edge
        end
    end

    assign start_stop_stb = btn_stb[0];
    assign clear_stb      = btn_stb[1];
    assign inc_stb        = btn_stb[2];
    assign prog_s         = sync2[3];
    assign up_s           = sync2[4];
    assign min_sel_s      = sync2[5];

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // a held button must give one strobe, not a train
    a_stb_single: assert property (@(posedge clk) disable iff (!rst_n)
        (btn_stb & $past(btn_stb)) == 3'b000)
        else $error("button strobe high for two cycles: %b", btn_stb);

endmodule

// ==== sw_tick_gen.sv ====
`timescale 1ns/1ps

module sw_tick_gen (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    import sw_pkg::*;

    tick_cnt_t cnt;

    // free running, one tick per tick_div clocks
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == tick_cnt_t'(tick_div - 32'd1)) begin
            cnt  <= '0;
            tick <= 1'b1;   // wrap cycle
        end else begin
            cnt  <= cnt + tick_cnt_t'(1);
            tick <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    a_tick_single: assert property (@(posedge clk) disable iff (!rst_n)
        tick |=> !tick)
        else $error("tick high for two consecutive cycles");

endmodule

// ==== sw_mode_fsm.sv ====
`timescale 1ns/1ps

module sw_mode_fsm (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_stop_stb,
    input  logic             clear_stb,
    input  logic             inc_stb,
    input  logic             prog_s,
    input  logic             up_s,
    input  logic             min_sel_s,
    input  logic             expired_stb,
    output logic             load_stb,
    output sw_pkg::time_cs_t load_value,
    output logic             run,
    output logic             count_up
);

    import sw_pkg::*;

    sw_state_t state;
    sw_state_t state_nxt;
    time_cs_t  preset;
    time_cs_t  preset_nxt;
    time_cs_t  preset_inc;    // preset plus one step, saturated
    time_cs_t  step;
    time_cs_t  start_value;
    time_cs_t  load_val_nxt;
    logic      load_nxt;
    logic      up_chg;

    // count_up holds last cycle's up_s, so it also serves for change detect
    assign up_chg = (up_s != count_up);
    assign step   = min_sel_s ? minute_cs : second_cs;

    always_comb begin
        if (preset > max_time_cs - step)
            preset_inc = max_time_cs;
        else
            preset_inc = preset + step;
    end

    // up counts from zero, down from the preset or the one minute default
    always_comb begin
        if (up_s)
            start_value = '0;
        else if (preset == '0)
            start_value = default_preset_cs;
        else
            start_value = preset;
    end

    ////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt    = state;
        preset_nxt   = preset;
        load_nxt     = 1'b0;
        load_val_nxt = start_value;
        if (prog_s) begin
            state_nxt = st_program;
            if (state != st_program) begin
                load_nxt     = 1'b1;     // show the preset on entry
                load_val_nxt = preset;
            end
            if (clear_stb) begin
                preset_nxt   = '0;
                load_nxt     = 1'b1;
                load_val_nxt = '0;
            end else if (inc_stb) begin
                preset_nxt   = preset_inc;
                load_nxt     = 1'b1;
                load_val_nxt = preset_inc;
            end
        end else if (state == st_program || up_chg || clear_stb) begin
            // leaving program, direction flip or clear all restart
            state_nxt = st_ready;
            load_nxt  = 1'b1;
        end else begin
            case (state)
                st_ready:   if (start_stop_stb) state_nxt = st_running;
                st_running: begin
                    if (expired_stb)
                        state_nxt = st_expired;
                    else if (start_stop_stb)
                        state_nxt = st_paused;
                end
                st_paused: begin
                    // expiry can land just after a pause
                    if (expired_stb)
                        state_nxt = st_expired;
                    else if (start_stop_stb)
                        state_nxt = st_running;
                end
                st_expired: state_nxt = st_expired;  // wait for clear, prog or up
                default:    state_nxt = st_ready;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_ready;
            preset   <= '0;
            load_stb <= 1'b0;
            run      <= 1'b0;
            count_up <= 1'b0;
        end else begin
            state    <= state_nxt;
            preset   <= preset_nxt;
            load_stb <= load_nxt;
            run      <= (state_nxt == st_running);
            count_up <= up_s;
        end
    end

    always_ff @(posedge clk) begin
        load_value <= load_val_nxt;   // only meaningful with load_stb
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    a_run_state: assert property (@(posedge clk) disable iff (!rst_n)
        run |-> state == st_running)
        else $error("run high in state %s", state.name());

    a_preset_max: assert property (@(posedge clk) disable iff (!rst_n)
        preset <= max_time_cs)
        else $error("preset %0d above maximum", preset);

endmodule

// ==== sw_time_counter.sv ====
`timescale 1ns/1ps

module sw_time_counter (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             tick,
    input  logic             load_stb,
    input  sw_pkg::time_cs_t load_value,
    input  logic             run,
    input  logic             count_up,
    output sw_pkg::time_cs_t time_cs,
    output logic             expired_stb
);

    import sw_pkg::*;

    logic at_max;
    logic at_zero;
    logic step_en;

    assign at_max  = (time_cs >= max_time_cs);
    assign at_zero = (time_cs == '0);
    assign step_en = tick && run;

    ////////////////////////////////////////////////////////////
    // time register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            time_cs     <= '0;
            expired_stb <= 1'b0;
        end else begin
            expired_stb <= 1'b0;
            if (load_stb) begin
                time_cs <= load_value;       // load wins over counting
            end else if (step_en) begin
                if (count_up) begin
                    if (!at_max)
                        time_cs <= time_cs + time_cs_t'(1);
                end else if (!at_zero) begin
                    time_cs <= time_cs - time_cs_t'(1);
                    // flag on the same edge that writes 0
                    if (time_cs == time_cs_t'(1))
                        expired_stb <= 1'b1;
                end
            end
        end
    end

    // once at zero a countdown stays there, so expiry fires only once

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    a_time_max: assert property (@(posedge clk) disable iff (!rst_n)
        time_cs <= max_time_cs)
        else $error("time_cs %0d above maximum", time_cs);

    a_expired_zero: assert property (@(posedge clk) disable iff (!rst_n)
        expired_stb |-> time_cs == '0)
        else $error("expired_stb with time_cs %0d", time_cs);

endmodule

// ==== stopwatch_top.sv ====
`timescale 1ns/1ps

module stopwatch_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_stop,
    input  logic             clear,
    input  logic             inc,
    input  logic             prog,
    input  logic             up,
    input  logic             min_sel,
    output sw_pkg::time_cs_t time_cs,
    output logic             zero
);

    import sw_pkg::*;

    // conditioned inputs
    logic start_stop_stb;
    logic clear_stb;
    logic inc_stb;
    logic prog_s;
    logic up_s;
    logic min_sel_s;

    logic     tick;
    logic     load_stb;
    time_cs_t load_value;
    logic     run;
    logic     count_up;

    ////////////////////////////////////////////////////////////
    // input conditioning, mode control, time counting
    ////////////////////////////////////////////////////////////

    sw_input_cond input_cond_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_stop     (start_stop),
        .clear          (clear),
        .inc            (inc),
        .prog           (prog),
        .up             (up),
        .min_sel        (min_sel),
        .start_stop_stb (start_stop_stb),
        .clear_stb      (clear_stb),
        .inc_stb        (inc_stb),
        .prog_s         (prog_s),
        .up_s           (up_s),
        .min_sel_s      (min_sel_s)
    );

    sw_tick_gen tick_gen_i (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    sw_mode_fsm mode_fsm_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_stop_stb (start_stop_stb),
        .clear_stb      (clear_stb),
        .inc_stb        (inc_stb),
        .prog_s         (prog_s),
        .up_s           (up_s),
        .min_sel_s      (min_sel_s),
        .expired_stb    (zero),         // expiry pulse doubles as the zero output
        .load_stb       (load_stb),
        .load_value     (load_value),
        .run            (run),
        .count_up       (count_up)
    );

    sw_time_counter time_counter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .tick        (tick),
        .load_stb    (load_stb),
        .load_value  (load_value),
        .run         (run),
        .count_up    (count_up),
        .time_cs     (time_cs),
        .expired_stb (zero)
    );

endmodule

// ==== tb_stopwatch.sv ====
`timescale 1ns/1ps

module tb_stopwatch;

    import sw_pkg::*;

    localparam int half_period = 4;
    localparam int clk_period  = 2 * half_period;
    localparam int test_cycles = 12500;    // upper bound on stimulus length
    localparam int btn_start   = 0;
    localparam int btn_clear   = 1;
    localparam int btn_inc     = 2;

    logic     clk;
    logic     rst_n;
    logic     start_stop;
    logic     clear;
    logic     inc;
    logic     prog;
    logic     up;
    logic     min_sel;
    time_cs_t time_cs;
    logic     zero;

    int       mismatches  = 0;
    int       failures    = 0;
    int       cycle       = 0;
    int       zero_pulses = 0;
    integer   seed;
    logic     up_watch;               // count-up checks armed
    time_cs_t prev_time;              // time_cs one edge back
    int       gap         = 0;        // cycles since the last step
    logic     stepped     = 1'b0;

    stopwatch_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_stop (start_stop),
        .clear      (clear),
        .inc        (inc),
        .prog       (prog),
        .up         (up),
        .min_sel    (min_sel),
        .time_cs    (time_cs),
        .zero       (zero)
    );

    always #(half_period) clk = ~clk;

    always @(posedge clk) begin
        cycle     <= cycle + 1;
        prev_time <= time_cs;
        if (zero)
            zero_pulses <= zero_pulses + 1;
    end

    ////////////////////////////////////////////////////////////
    // checks running alongside the stimulus
    ////////////////////////////////////////////////////////////

    // steps while counting up must be tick_div cycles apart
    always @(posedge clk) begin
        if (!up_watch) begin
            stepped <= 1'b0;
            gap     <= 0;
        end else if (time_cs != prev_time) begin
            assert (!stepped || gap >= int'(tick_div))
            else begin
                failures = failures + 1;
                $display("time_cs stepped %0d cycles after the last step at %0t", gap, $time);
            end
            stepped <= 1'b1;
            gap     <= 1;
        end else begin
            gap <= gap + 1;
        end
    end

    a_zero_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        zero |=> !zero)
        else begin
            mismatches = mismatches + 1;
            $display("Mismatch at %0t: zero expected 0 got 1 after a pulse", $time);
        end

    a_zero_at_0: assert property (@(posedge clk) disable iff (!rst_n)
        zero |-> time_cs == time_cs_t'(0))
        else begin
            mismatches = mismatches + 1;
            $display("Mismatch at %0t: time_cs expected 0 got %0d at zero pulse",
                     $time, $sampled(time_cs));
        end

    a_count_up: assert property (@(posedge clk) disable iff (!rst_n)
        up_watch |-> time_cs >= prev_time && time_cs - prev_time <= time_cs_t'(1))
        else begin
            mismatches = mismatches + 1;
            $display("Mismatch at %0t: time_cs expected %0d or one more got %0d",
                     $time, $sampled(prev_time), $sampled(time_cs));
        end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #1;                           // drive just after the edge
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic set_button(input int which, input logic level);
        case (which)
            btn_start: start_stop = level;
            btn_clear: clear = level;
            default:   inc = level;
        endcase
    endtask

    // 2 high, 2 low, then 8 to settle
    task automatic press_button(input int which);
        set_button(which, 1'b1);
        wait_cycles(2);
        set_button(which, 1'b0);
        wait_cycles(10);
    endtask

    task automatic check_time(input time_cs_t expected, input string what);
        assert (time_cs == expected)
        else begin
            mismatches = mismatches + 1;
            $display("Mismatch at %0t: time_cs expected %0d got %0d (%s)",
                     $time, expected, time_cs, what);
        end
    endtask

    task automatic check_range(input int lo, input int hi, input string what);
        assert (int'(time_cs) >= lo && int'(time_cs) <= hi)
        else begin
            mismatches = mismatches + 1;
            $display("Mismatch at %0t: time_cs expected %0d..%0d got %0d (%s)",
                     $time, lo, hi, time_cs, what);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int       run_len;
        int       window;
        int       start_cycle;
        int       elapsed;
        int       waited;
        time_cs_t hold;
        clk        = 1'b0;
        rst_n      = 1'b0;
        start_stop = 1'b0;
        clear      = 1'b0;
        inc        = 1'b0;
        prog       = 1'b0;
        up         = 1'b1;       // so that dropping it later is a change
        min_sel    = 1'b0;
        up_watch   = 1'b0;
        seed       = 32'hdc76;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;

        // reset state, then default countdown
        next_cycle();
        check_time(time_cs_t'(0), "after reset");
        assert (zero == 1'b0)
        else begin
            mismatches = mismatches + 1;
            $display("Mismatch at %0t: zero expected 0 got %b", $time, zero);
        end
        wait_cycles(8);
        up = 1'b0;
        wait_cycles(8);
        check_time(default_preset_cs, "default countdown");

        // program two minutes and three seconds
        prog = 1'b1;
        wait_cycles(8);
        min_sel = 1'b1;
        wait_cycles(8);
        press_button(btn_inc);
        press_button(btn_inc);
        min_sel = 1'b0;
        wait_cycles(8);
        repeat (3) press_button(btn_inc);
        check_time(time_cs_t'(2 * minute_cs + 3 * second_cs), "programmed preset");
        press_button(btn_clear);
        check_time(time_cs_t'(0), "preset cleared");
        prog = 1'b0;
        wait_cycles(8);
        check_time(default_preset_cs, "zero preset leaves program");

        // count up, then pause
        up = 1'b1;
        wait_cycles(8);
        check_time(time_cs_t'(0), "count-up start");
        run_len = 100 + int'($unsigned($random(seed)) % 32'd300);
        window  = 12 + run_len;  // start press to pause press
        up_watch = 1'b1;
        press_button(btn_start);
        wait_cycles(run_len);
        press_button(btn_start);
        check_range(window / int'(tick_div) - 1, window / int'(tick_div) + 1, "paused");
        hold = time_cs;
        repeat (100) begin
            next_cycle();
            check_time(hold, "held in pause");
        end
        up_watch = 1'b0;

        // one second countdown to expiry
        up = 1'b0;
        wait_cycles(8);
        prog = 1'b1;
        wait_cycles(8);
        press_button(btn_inc);
        prog = 1'b0;
        wait_cycles(8);
        check_time(second_cs, "one second preset");
        start_cycle = cycle;
        press_button(btn_start);
        waited = 0;
        while (zero !== 1'b1 && waited < 2 * int'(second_cs) * int'(tick_div)) begin
            next_cycle();
            waited = waited + 1;
        end
        elapsed = cycle - start_cycle;
        assert (zero === 1'b1)
        else begin
            failures = failures + 1;
            $display("countdown never reached zero, gave up at %0t", $time);
        end
        assert (elapsed >= int'(second_cs) * int'(tick_div))
        else begin
            mismatches = mismatches + 1;
            $display("Mismatch at %0t: countdown cycles expected >= %0d got %0d",
                     $time, int'(second_cs) * int'(tick_div), elapsed);
        end
        check_time(time_cs_t'(0), "at expiry");
        wait_cycles(50);
        check_time(time_cs_t'(0), "after expiry");
        assert (zero_pulses == 1)
        else begin
            mismatches = mismatches + 1;
            $display("Mismatch at %0t: zero pulse count expected 1 got %0d", $time, zero_pulses);
        end

        // clear while counting up, then while counting down
        up = 1'b1;
        wait_cycles(8);
        press_button(btn_start);
        wait_cycles(200);
        check_range(1, int'(max_time_cs), "counting up");
        press_button(btn_clear);
        check_time(time_cs_t'(0), "cleared count-up");
        wait_cycles(50);
        check_time(time_cs_t'(0), "count-up stays cleared");
        up = 1'b0;
        wait_cycles(8);
        check_time(second_cs, "countdown reload");
        press_button(btn_start);
        wait_cycles(200);
        check_range(1, int'(second_cs) - 1, "counting down");
        press_button(btn_clear);
        check_time(second_cs, "cleared countdown");
        wait_cycles(50);
        check_time(second_cs, "countdown stays cleared");

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    // about three times the longest stimulus
    initial begin
        #(3 * test_cycles * clk_period);
        failures = failures + 1;
        $display("timeout: the tests did not finish within %0d cycles", 3 * test_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== compile.f ====
sw_pkg.sv
sw_input_cond.sv
sw_tick_gen.sv
sw_mode_fsm.sv
sw_time_counter.sv
stopwatch_top.sv
tb_stopwatch.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the stopwatch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_stopwatch \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
